// File: project.f
hdl/midi_pkg.sv
hdl/dsp_alu_pkg.sv
hdl/note_decoder.sv
hdl/voice_sequencer.sv
hdl/phase_fold.sv
hdl/alu_request.sv
hdl/sine_voice.sv
dv/sine_voice_props.sv
dv/sine_voice_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the sine voice testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module sine_voice_tb \
    -f project.f \
    -Mdir obj_dir -o sim_sine_voice
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/sim_sine_voice
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation reported failure"
    exit $status
fi

exit 0

// File: dv/sine_voice_tb.sv
// ----------------------------------------------------------------------
// Sine voice testbench
// Random MIDI events and sample triggers, a queued DSP ALU model with
// random latency and stall, and a reference model of the voice
// ----------------------------------------------------------------------

`default_nettype none

module sine_voice_tb
    import midi_pkg::*;
    import dsp_alu_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_CYCLES  = 200000;
    localparam int PASS_TARGET = 1500;
    localparam int PASS_LIMIT  = 300;
    localparam int QUIET_START = 200;

    logic       clk;
    logic       reset;
    logic       midi_rdy;
    midi_cmd_t  midi_cmd;
    logic [3:0] midi_channel;
    note_t      midi_data0;
    velocity_t  midi_data1;
    logic       smp_trig;
    logic       smp_out_rdy;
    operand_t   smp_out;
    logic       alu_cycle;
    logic       alu_strobe;
    logic       alu_stall;
    logic       alu_ack;
    alu_op_t    alu_op;
    operand_t   alu_a;
    operand_t   alu_b;
    acc_t       alu_c;
    acc_t       alu_p;

    logic [31:0] rng;
    int          sin_lut [1024];
    int          cyc;
    acc_t        res_q [$];
    int          due_q [$];
    int          last_due;

    // Reference model of the voice
    logic     m_note_on;
    int       m_vel;
    int       m_step;
    int       m_phase;
    logic     m_dir_up;
    logic     m_half_neg;
    operand_t m_sin;

    logic exp_rdy;
    logic exp_rdy_d;
    logic pass_active;
    logic cycle_seen;
    int   busy;
    int   quiet;
    int   sin_seen;
    int   pass_strobes;
    int   passes;
    int   lower_hits;
    int   upper_hits;
    int   note_offs;

    sine_voice dut (
        .clk          (clk),
        .reset        (reset),
        .midi_rdy     (midi_rdy),
        .midi_cmd     (midi_cmd),
        .midi_channel (midi_channel),
        .midi_data0   (midi_data0),
        .midi_data1   (midi_data1),
        .smp_trig     (smp_trig),
        .smp_out_rdy  (smp_out_rdy),
        .smp_out      (smp_out),
        .alu_cycle    (alu_cycle),
        .alu_strobe   (alu_strobe),
        .alu_stall    (alu_stall),
        .alu_ack      (alu_ack),
        .alu_op       (alu_op),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .alu_c        (alu_c),
        .alu_p        (alu_p)
    );

    bind voice_sequencer sine_voice_props u_props (
        .clk       (clk),
        .reset     (reset),
        .state     (state),
        .alu_stall (alu_stall),
        .alu_ack   (alu_ack),
        .alu_cycle (alu_cycle),
        .lower_hit (lower_hit)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift_next();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Quarter-wave sine with one table entry per 128 phase units
    function automatic operand_t quarter_sin(operand_t a);
        return operand_t'(sin_lut[a[16:7]]);
    endfunction

    function automatic int step_for_note(int n);
        int shift;
        shift = int'(TOP_OCTAVE) - n / 12;
        return int'(NOTE_STEP_BASE[n % 12]) >> shift;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [47:0] got,
                               input logic [47:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // Whole voice pass, applied when its SIN request goes out
    task automatic model_pass();
        int     vel_q;
        longint prod;
        int     newp;
        vel_q = m_vel << 9;
        if (m_half_neg) begin
            vel_q = -vel_q;
        end
        prod  = longint'(quarter_sin(operand_t'(m_phase))) * longint'(vel_q);
        m_sin = operand_t'(prod >>> 16);
        newp  = m_dir_up ? m_phase + m_step : m_phase - m_step;
        if (!m_dir_up && newp < 0) begin
            m_phase    = 0;
            m_dir_up   = 1'b1;
            m_half_neg = ~m_half_neg;
            lower_hits++;
        end else if (int'(PI_HALF) - newp < 0) begin
            m_phase  = int'(PI_HALF);
            m_dir_up = 1'b0;
            upper_hits++;
        end else begin
            m_phase = newp;
        end
    endtask

    task automatic alu_accept();
        acc_t aw;
        acc_t bw;
        acc_t res;
        operand_t s;
        int d;
        aw = acc_t'(alu_a);
        bw = acc_t'(alu_b);
        case (alu_op)
            ALU_SIN: begin
                s   = quarter_sin(alu_a);
                res = {{14{s[17]}}, s, 16'h0000};
            end
            ALU_MUL:    res = aw * bw;
            ALU_MULADD: res = alu_c + aw * bw;
            ALU_MULSUB: res = alu_c - aw * bw;
            default: begin
                res = '0;
                fail_run("ALU received an unknown opcode");
            end
        endcase
        d = 1 + int'(xorshift_next() % 32'd6);
        last_due = (cyc + d > last_due) ? cyc + d : last_due + 1;
        res_q.push_back(res);
        due_q.push_back(last_due);
    endtask

    task automatic sample_cycle();
        check_value("smp_out_rdy", 48'(smp_out_rdy), 48'(exp_rdy));
        if (smp_out_rdy) begin
            check_value("smp_out", 48'(smp_out), 48'(m_sin));
            check_value("alu_cycle", 48'(alu_cycle), 48'(1'b1));
            cycle_seen = 1'b1;
        end
        exp_rdy   = exp_rdy_d;
        exp_rdy_d = 1'b0;

        if (!pass_active) begin
            check_value("alu_cycle", 48'(alu_cycle), 48'(1'b0));
        end else if (cycle_seen && !alu_cycle) begin
            check_value("sin_requests", 48'(sin_seen), 48'(1));
            check_value("alu_outstanding", 48'(res_q.size()), 48'(0));
            pass_active  = 1'b0;
            cycle_seen   = 1'b0;
            sin_seen     = 0;
            pass_strobes = 0;
            passes++;
        end else begin
            busy++;
            if (busy > PASS_LIMIT) begin
                fail_run("Timeout: a pass did not finish in time");
            end
        end

        if (pass_active || alu_cycle) begin
            quiet = 0;
        end else if (quiet < 1000) begin
            quiet++;
        end

        if (alu_strobe) begin
            check_value("alu_cycle", 48'(alu_cycle), 48'(1'b1));
            pass_strobes++;
            if (alu_op == ALU_SIN) begin
                check_value("alu_stall", 48'(alu_stall), 48'(1'b0));
                check_value("alu_a", 48'(alu_a), 48'(operand_t'(m_phase)));
                sin_seen++;
                model_pass();
            end
            alu_accept();
        end
    endtask

    task automatic send_midi(input logic off_only);
        logic [31:0] r;
        int          n;
        r = xorshift_next();
        n = 84 + int'(r[15:8]) % 44;
        midi_rdy     = 1'b1;
        midi_channel = r[3:0];
        midi_data0   = note_t'(n);
        midi_data1   = r[22:16];
        quiet        = 0;
        if (!off_only && r[26:24] < 3'd5) begin
            midi_cmd  = MIDI_NOTE_ON;
            m_note_on = 1'b1;
            m_vel     = int'(r[22:16]);
            m_step    = step_for_note(n);
        end else if (off_only || r[26:24] < 3'd7) begin
            midi_cmd  = MIDI_NOTE_OFF;
            m_note_on = 1'b0;
            note_offs++;
        end else begin
            // Control change that the voice ignores
            midi_cmd = 4'hb;
        end
    endtask

    task automatic drive_cycle();
        logic [31:0] r;
        r = xorshift_next();
        if (res_q.size() > 0 && due_q[0] <= cyc + 1) begin
            alu_ack = 1'b1;
            alu_p   = res_q.pop_front();
            void'(due_q.pop_front());
        end else begin
            alu_ack = 1'b0;
            alu_p   = {r, r[15:0]};
        end
        alu_stall = (xorshift_next() % 32'd3) == 32'd0;
        midi_rdy  = 1'b0;
        smp_trig  = 1'b0;
        r = xorshift_next();
        if (cyc > QUIET_START && !pass_active && quiet >= 3 && r[2:0] == 3'd0) begin
            send_midi(1'b0);
        end else if (pass_active && m_note_on && pass_strobes >= 3 && r[7:5] == 3'd0) begin
            // Note Off once the pass no longer needs velocity or step
            send_midi(1'b1);
        end else if ((pass_active || quiet >= 3) && r[4:3] == 2'd0) begin
            smp_trig = 1'b1;
            if (!pass_active && m_note_on) begin
                exp_rdy_d   = 1'b1;
                pass_active = 1'b1;
                busy        = 0;
            end
        end
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        midi_rdy     = 1'b0;
        midi_cmd     = '0;
        midi_channel = '0;
        midi_data0   = '0;
        midi_data1   = '0;
        smp_trig     = 1'b0;
        alu_stall    = 1'b0;
        alu_ack      = 1'b0;
        alu_p        = '0;
        rng          = 32'h4abf_07a6;
        cyc          = 0;
        last_due     = 0;
        busy         = 0;
        quiet        = 0;
        sin_seen     = 0;
        pass_strobes = 0;
        passes       = 0;
        lower_hits   = 0;
        upper_hits   = 0;
        note_offs    = 0;
        m_note_on    = 1'b0;
        m_vel        = 0;
        m_step       = 0;
        m_phase      = 0;
        m_dir_up     = 1'b1;
        m_half_neg   = 1'b0;
        m_sin        = '0;
        exp_rdy      = 1'b0;
        exp_rdy_d    = 1'b0;
        pass_active  = 1'b0;
        cycle_seen   = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            sin_lut[i] = $rtoi($sin(real'(i) * 128.0 / 65536.0) * 65536.0 + 0.5);
        end

        repeat (16) @(negedge clk);
        reset = 1'b0;

        while (passes < PASS_TARGET && cyc < MAX_CYCLES) begin
            @(posedge clk);
            cyc++;
            sample_cycle();
            @(negedge clk);
            drive_cycle();
        end

        if (passes < PASS_TARGET) begin
            fail_run("Timeout: too few passes completed");
        end else if (lower_hits > 0 && upper_hits > 0 && note_offs > 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            fail_run("Run ended without a fold at both bounds and a Note Off");
        end
    end

endmodule

`default_nettype wire

// File: dv/sine_voice_props.sv
// ----------------------------------------------------------------------
// Sine voice ALU handshake properties
// Counts the outstanding ALU operations of the voice sequencer
// ----------------------------------------------------------------------

`default_nettype none

module sine_voice_props
    import dsp_alu_pkg::*;
(
    input wire logic       clk,
    input wire logic       reset,
    input wire seq_state_t state,
    input wire logic       alu_stall,
    input wire logic       alu_ack,
    input wire logic       alu_cycle,
    input wire logic       lower_hit
);

    timeunit 1ns;
    timeprecision 100ps;

    logic       strobe;
    logic [2:0] outstanding;

    // Strobe conditions of the request builder as seen from the FSM
    assign strobe = ((state == REQ_SIN) && !alu_stall)
                 || ((state == REQ_SCALE) && alu_ack)
                 || (state == REQ_STEP)
                 || ((state == TAKE_STEP) && alu_ack && !lower_hit);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + 3'(strobe) - 3'(alu_ack);
        end
    end

    a_two_in_flight: assert property (@(posedge clk) disable iff (reset)
        outstanding <= 3'd2)
        else $error("more than two ALU operations outstanding");

    a_ack_owed: assert property (@(posedge clk) disable iff (reset)
        alu_ack |-> (outstanding != 3'd0))
        else $error("ALU ack without an outstanding operation");

    a_cycle_on_ack: assert property (@(posedge clk) disable iff (reset)
        alu_ack |-> alu_cycle)
        else $error("ALU ack outside of alu_cycle");

endmodule

`default_nettype wire

// File: hdl/sine_voice.sv
// ----------------------------------------------------------------------
// Sine voice top level
// MIDI-driven mono sine voice that computes one sample per trigger
// on an external DSP ALU
// ----------------------------------------------------------------------

`default_nettype none

module sine_voice
    import midi_pkg::*;
    import dsp_alu_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,

    input  wire logic       midi_rdy,
    input  wire midi_cmd_t  midi_cmd,
    input  wire logic [3:0] midi_channel,
    input  wire note_t      midi_data0,
    input  wire velocity_t  midi_data1,

    input  wire logic       smp_trig,
    output logic            smp_out_rdy,
    output operand_t        smp_out,

    // DSP ALU
    output logic            alu_cycle,
    output logic            alu_strobe,
    input  wire logic       alu_stall,
    input  wire logic       alu_ack,
    output alu_op_t         alu_op,
    output operand_t        alu_a,
    output operand_t        alu_b,
    output acc_t            alu_c,
    input  wire acc_t       alu_p
);

    logic       note_on;
    velocity_t  velocity;
    operand_t   phase_step;
    seq_state_t state;
    logic       take_sin;
    logic       take_step;
    logic       take_fold;
    logic       lower_hit;
    logic       upper_hit;
    operand_t   phase;
    logic       dir_up;
    logic       half_neg;
    operand_t   sin_val;

    // Voice listens on every channel
    note_decoder u_note_decoder (
        .clk        (clk),
        .reset      (reset),
        .midi_rdy   (midi_rdy),
        .midi_cmd   (midi_cmd),
        .midi_data0 (midi_data0),
        .midi_data1 (midi_data1),
        .note_on    (note_on),
        .velocity   (velocity),
        .phase_step (phase_step)
    );

    voice_sequencer u_voice_sequencer (
        .clk         (clk),
        .reset       (reset),
        .note_on     (note_on),
        .smp_trig    (smp_trig),
        .alu_stall   (alu_stall),
        .alu_ack     (alu_ack),
        .lower_hit   (lower_hit),
        .upper_hit   (upper_hit),
        .sin_val     (sin_val),
        .alu_cycle   (alu_cycle),
        .state       (state),
        .take_sin    (take_sin),
        .take_step   (take_step),
        .take_fold   (take_fold),
        .smp_out_rdy (smp_out_rdy),
        .smp_out     (smp_out)
    );

    phase_fold u_phase_fold (
        .clk       (clk),
        .reset     (reset),
        .take_sin  (take_sin),
        .take_step (take_step),
        .take_fold (take_fold),
        .alu_p     (alu_p),
        .phase     (phase),
        .dir_up    (dir_up),
        .half_neg  (half_neg),
        .sin_val   (sin_val),
        .lower_hit (lower_hit),
        .upper_hit (upper_hit)
    );

    alu_request u_alu_request (
        .state      (state),
        .alu_stall  (alu_stall),
        .alu_ack    (alu_ack),
        .phase      (phase),
        .dir_up     (dir_up),
        .half_neg   (half_neg),
        .velocity   (velocity),
        .phase_step (phase_step),
        .alu_p      (alu_p),
        .alu_strobe (alu_strobe),
        .alu_op     (alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_c      (alu_c)
    );

endmodule

`default_nettype wire

// File: hdl/alu_request.sv
// ----------------------------------------------------------------------
// ALU request builder
// Combinational opcode, operands and strobe for the request that
// belongs to the current sequencer state
// ----------------------------------------------------------------------

`default_nettype none

module alu_request
    import dsp_alu_pkg::*;
(
    input  wire seq_state_t state,
    input  wire logic       alu_stall,
    input  wire logic       alu_ack,
    input  wire operand_t   phase,
    input  wire logic       dir_up,
    input  wire logic       half_neg,
    input  wire logic [6:0] velocity,
    input  wire operand_t   phase_step,
    input  wire acc_t       alu_p,
    output logic            alu_strobe,
    output alu_op_t         alu_op,
    output operand_t        alu_a,
    output operand_t        alu_b,
    output acc_t            alu_c
);

    operand_t p_field;
    operand_t vel_q;
    operand_t scale_b;
    acc_t     phase_wide;
    acc_t     pi_half_wide;
    logic     step_low;

    assign p_field = alu_p[33:16];

    // Velocity 0..127 as 0..127/128 in Q2.16, sign from the half wave
    assign vel_q   = {2'b00, velocity, 9'h000};
    assign scale_b = half_neg ? -vel_q : vel_q;

    // Q2.16 aligned to the product's Q4.32 point
    assign phase_wide   = {{14{phase[17]}}, phase, 16'h0000};
    assign pi_half_wide = {{14{PI_HALF[17]}}, PI_HALF, 16'h0000};

    // Same bound as the fold logic, no fold request after it
    assign step_low = !dir_up && alu_p[47];

    always_comb begin
        alu_strobe = 1'b0;
        alu_op     = ALU_NOP;
        alu_a      = '0;
        alu_b      = '0;
        alu_c      = '0;
        case (state)
            REQ_SIN: begin
                alu_strobe = !alu_stall;
                alu_op     = ALU_SIN;
                alu_a      = phase;
            end
            REQ_SCALE: begin
                alu_strobe = alu_ack;
                alu_op     = ALU_MUL;
                alu_a      = p_field;
                alu_b      = scale_b;
            end
            REQ_STEP: begin
                alu_strobe = 1'b1;
                alu_op     = dir_up ? ALU_MULADD : ALU_MULSUB;
                alu_a      = phase_step;
                alu_b      = UNITY;
                alu_c      = phase_wide;
            end
            // pi/2 - new phase
            TAKE_STEP: begin
                alu_strobe = alu_ack && !step_low;
                alu_op     = ALU_MULSUB;
                alu_a      = p_field;
                alu_b      = UNITY;
                alu_c      = pi_half_wide;
            end
            default: begin
                alu_strobe = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/phase_fold.sv
// ----------------------------------------------------------------------
// Phase fold
// Holds phase, sweep direction, half-wave sign and the scaled sine.
// Folds the quarter-wave sweep at zero and at pi/2
// ----------------------------------------------------------------------

`default_nettype none

module phase_fold
    import dsp_alu_pkg::*;
(
    input  wire logic take_sin,
    input  wire logic take_step,
    input  wire logic take_fold,
    input  wire acc_t alu_p,
    input  wire logic clk,
    input  wire logic reset,
    output operand_t  phase,
    output logic      dir_up,
    output logic      half_neg,
    output operand_t  sin_val,
    output logic      lower_hit,
    output logic      upper_hit
);

    logic     p_neg;
    operand_t p_field;

    assign p_neg   = alu_p[47];
    assign p_field = alu_p[33:16];

    // Descending sweep went below zero
    assign lower_hit = take_step && !dir_up && p_neg;
    // pi/2 - phase < 0, sweep went past the peak
    assign upper_hit = take_fold && p_neg;

    // ------------------------------------------------------------------
    // Phase, direction and sign
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase    <= '0;
            dir_up   <= 1'b1;
            half_neg <= 1'b0;
        end else if (lower_hit) begin
            phase    <= '0;
            dir_up   <= 1'b1;
            half_neg <= ~half_neg;
        end else if (upper_hit) begin
            phase  <= PI_HALF;
            dir_up <= 1'b0;
        end else if (take_step) begin
            phase <= p_field;
        end
    end

    // Scaled sine, sent out at the start of the next pass
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sin_val <= '0;
        end else if (take_sin) begin
            sin_val <= p_field;
        end
    end

endmodule

`default_nettype wire

// File: hdl/voice_sequencer.sv
// ----------------------------------------------------------------------
// Voice sequencer
// Per-sample FSM that sends out the previous sample, orders the ALU
// requests of one pass and tells the fold logic when to take results
// ----------------------------------------------------------------------

`default_nettype none

module voice_sequencer
    import dsp_alu_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     note_on,
    input  wire logic     smp_trig,
    input  wire logic     alu_stall,
    input  wire logic     alu_ack,
    input  wire logic     lower_hit,
    input  wire logic     upper_hit,
    input  wire operand_t sin_val,
    output logic          alu_cycle,
    output seq_state_t    state,
    output logic          take_sin,
    output logic          take_step,
    output logic          take_fold,
    output logic          smp_out_rdy,
    output operand_t      smp_out
);

    // Scale ack may already come back while the step add is issued
    assign take_sin  = alu_ack && ((state == REQ_STEP) || (state == TAKE_SIN));
    assign take_step = alu_ack && (state == TAKE_STEP);
    assign take_fold = alu_ack && (state == TAKE_FOLD);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= IDLE;
            alu_cycle   <= 1'b0;
            smp_out_rdy <= 1'b0;
            smp_out     <= '0;
        end else begin
            smp_out_rdy <= 1'b0;
            case (state)
                IDLE: begin
                    if (note_on) begin
                        state <= WAIT_TRIG;
                    end
                end
                WAIT_TRIG: begin
                    if (!note_on) begin
                        state <= IDLE;
                    end else if (smp_trig) begin
                        state       <= REQ_SIN;
                        alu_cycle   <= 1'b1;
                        smp_out_rdy <= 1'b1;
                        smp_out     <= sin_val;
                    end
                end
                REQ_SIN: begin
                    if (!alu_stall) begin
                        state <= REQ_SCALE;
                    end
                end
                // Scale multiply goes out with the sine ack
                REQ_SCALE: begin
                    if (alu_ack) begin
                        state <= REQ_STEP;
                    end
                end
                REQ_STEP: begin
                    state <= take_sin ? TAKE_STEP : TAKE_SIN;
                end
                TAKE_SIN: begin
                    if (take_sin) begin
                        state <= TAKE_STEP;
                    end
                end
                // Lower bound ends the pass, no fold needed
                TAKE_STEP: begin
                    if (take_step) begin
                        if (lower_hit) begin
                            state     <= IDLE;
                            alu_cycle <= 1'b0;
                        end else begin
                            state <= TAKE_FOLD;
                        end
                    end
                end
                TAKE_FOLD: begin
                    if (take_fold) begin
                        state     <= IDLE;
                        alu_cycle <= 1'b0;
                    end
                end
                default: begin
                    state     <= IDLE;
                    alu_cycle <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/note_decoder.sv
// ----------------------------------------------------------------------
// MIDI note decoder
// Latches note and velocity on Note On, clears them on Note Off, and
// derives the per-sample phase step from the note number
// ----------------------------------------------------------------------

`default_nettype none

module note_decoder
    import midi_pkg::*;
    import dsp_alu_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      midi_rdy,
    input  wire midi_cmd_t midi_cmd,
    input  wire note_t     midi_data0,
    input  wire velocity_t midi_data1,
    output logic           note_on,
    output velocity_t      velocity,
    output operand_t       phase_step
);

    logic       note_on_evt;
    logic       note_off_evt;
    note_t      note;
    logic [3:0] octave;
    note_t      note_rem;
    logic [3:0] semitone;

    assign note_on_evt  = midi_rdy && (midi_cmd == MIDI_NOTE_ON);
    assign note_off_evt = midi_rdy && (midi_cmd == MIDI_NOTE_OFF);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            note     <= '0;
            velocity <= '0;
            note_on  <= 1'b0;
        end else if (note_off_evt) begin
            note     <= '0;
            velocity <= '0;
            note_on  <= 1'b0;
        end else if (note_on_evt) begin
            note     <= midi_data0;
            velocity <= midi_data1;
            note_on  <= 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // Step lookup, octave by comparison then semitone table
    // ------------------------------------------------------------------
    always_comb begin
        octave = '0;
        for (int i = 1; i <= TOP_OCTAVE; i++) begin
            if (note >= 7'(12 * i)) begin
                octave = 4'(i);
            end
        end
        // note - 12 * octave
        note_rem = note - {octave, 3'b000} - {1'b0, octave, 2'b00};
        semitone = note_rem[3:0];
    end

    assign phase_step = operand_t'(NOTE_STEP_BASE[semitone] >> (4'(TOP_OCTAVE) - octave));

endmodule

`default_nettype wire

// File: hdl/dsp_alu_pkg.sv
// ----------------------------------------------------------------------
// DSP ALU definitions
// Opcode encoding, Q2.16 operand and 48-bit accumulator types,
// fixed-point constants and the voice sequencer states
// ----------------------------------------------------------------------

`default_nettype none

package dsp_alu_pkg;

    typedef logic [8:0]         alu_op_t;
    typedef logic signed [17:0] operand_t;
    typedef logic signed [47:0] acc_t;

    // Opcode fields
    localparam alu_op_t OPF_XIN_MULT    = 9'h001;
    localparam alu_op_t OPF_ZIN_CIN     = 9'h004;
    localparam alu_op_t OPF_POSTADD_SUB = 9'h008;
    localparam alu_op_t OPF_FUNC_SIN    = 9'h100;

    localparam alu_op_t ALU_NOP    = 9'h000;
    localparam alu_op_t ALU_SIN    = OPF_FUNC_SIN;
    // p = a * b
    localparam alu_op_t ALU_MUL    = OPF_XIN_MULT;
    // p = c + a * b
    localparam alu_op_t ALU_MULADD = OPF_XIN_MULT | OPF_ZIN_CIN;
    // p = c - a * b
    localparam alu_op_t ALU_MULSUB = OPF_XIN_MULT | OPF_ZIN_CIN | OPF_POSTADD_SUB;

    // Q2.16 constants
    localparam operand_t PI_HALF   = 18'sh19220;
    localparam operand_t UNITY     = 18'sh10000;
    localparam operand_t NEG_UNITY = 18'sh30000;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_TRIG,
        REQ_SIN,
        REQ_SCALE,
        REQ_STEP,
        TAKE_SIN,
        TAKE_STEP,
        TAKE_FOLD
    } seq_state_t;

endpackage

`default_nettype wire

// File: hdl/midi_pkg.sv
// ----------------------------------------------------------------------
// MIDI definitions for the sine voice
// Command nibbles, note and velocity types, and the phase steps of
// the top octave from which every other note's step is derived
// ----------------------------------------------------------------------

`default_nettype none

package midi_pkg;

    typedef logic [3:0] midi_cmd_t;
    typedef logic [6:0] note_t;
    typedef logic [6:0] velocity_t;

    localparam midi_cmd_t MIDI_NOTE_OFF = 4'h8;
    localparam midi_cmd_t MIDI_NOTE_ON  = 4'h9;

    // Q2.16 phase steps for notes 120..131, equal-tempered
    // All stay below pi/2 / 8 so a quarter wave spans several samples
    localparam logic [17:0] NOTE_STEP_BASE [12] = '{
        18'd6780,  18'd7183,  18'd7610,  18'd8063,
        18'd8542,  18'd9050,  18'd9588,  18'd10159,
        18'd10763, 18'd11403, 18'd12081, 18'd12799
    };

    // Octave of NOTE_STEP_BASE, one right shift per octave below
    localparam int unsigned TOP_OCTAVE = 10;

endpackage

`default_nettype wire
